// ==== apbUart.f ====
+incdir+src
src/apbUartPkg.sv
src/syncFifo.sv
src/baudGen.sv
src/uartTx.sv
src/uartRx.sv
src/uartRegs.sv
src/apbUart.sv
testbench/apbUartTb.sv

// ==== Bender.yml ====
package:
  name: apb_uart

sources:
  - include_dirs:
      - src
    files:
      - src/apbUartPkg.sv
      - src/syncFifo.sv
      - src/baudGen.sv
      - src/uartTx.sv
      - src/uartRx.sv
      - src/uartRegs.sv
      - src/apbUart.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/apbUartTb.sv

// ==== testbench/apbUartTb.sv ====
// Directed testbench for the APB UART
// Serial tests run at divisor 2, so one bit lasts 32 clocks
// The serial driver and monitor assume the 8N1 format and an idle-high line
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module apbUartTb;
	localparam int divVal = 2;
	localparam int bitClks = 16 * divVal;
	localparam int maxPolls = 1000;
	localparam logic [7:0] lsrDr = 8'h1 << `UART_LSR_DR;
	localparam logic [7:0] lsrOe = 8'h1 << `UART_LSR_OE;
	localparam logic [7:0] lsrFe = 8'h1 << `UART_LSR_FE;
	localparam logic [7:0] lsrThre = 8'h1 << `UART_LSR_THRE;
	localparam logic [7:0] lsrTemt = 8'h1 << `UART_LSR_TEMT;
	localparam logic [7:0] lsrIdle = lsrThre | lsrTemt;

	logic        CLK;
	logic        iRST;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [2:0]  PADDR;
	logic [31:0] PWDATA;
	logic        SIN;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        SOUT;

	int passCount;
	int failCount;
	int errs;
	bit watchSout;
	bit soutDropped;

	apbUart dut (
		.CLK, .iRST, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .SIN,
		.PRDATA, .PREADY, .SOUT
	);

	always #4 CLK = ~CLK;

	// SOUT has to stay idle while loopback traffic runs
	always @(negedge CLK)
	begin
		if (watchSout && SOUT !== 1'b1)
			soutDropped = 1'b1;
	end

	task automatic wrongValue(input string testName, input string what,
		input logic [7:0] expVal, input logic [7:0] actVal);
		$display("error %s: %s expected %h actual %h", testName, what, expVal, actVal);
		errs++;
	endtask

	task automatic finishTest(input string testName);
		if (errs == 0)
		begin
			passCount++;
			$display("%s: pass", testName);
		end
		else
		begin
			failCount++;
			$display("%s: fail with %0d errors", testName, errs);
		end
	endtask

	task automatic apbWrite(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK);
		#1;
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b1;
		PADDR = addr;
		PWDATA = {24'h0, data};
		@(posedge CLK);
		#1;
		PENABLE = 1'b1;
		// Zero wait states, so PREADY is already high in the access phase
		#3;
		if (PREADY !== 1'b1)
		begin
			$display("apbWrite: PREADY was low in the access phase at offset %0d", addr);
			errs++;
		end
		@(posedge CLK);
		#1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apbRead(input logic [2:0] addr, output logic [7:0] data);
		@(posedge CLK);
		#1;
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = addr;
		@(posedge CLK);
		#1;
		PENABLE = 1'b1;
		// PRDATA is combinational and is sampled well inside the access cycle
		#3;
		data = PRDATA[7:0];
		if (PRDATA[31:8] !== 24'h0)
		begin
			$display("apbRead: upper PRDATA bits are not zero at offset %0d", addr);
			errs++;
		end
		if (PREADY !== 1'b1)
		begin
			$display("apbRead: PREADY was low in the access phase at offset %0d", addr);
			errs++;
		end
		@(posedge CLK);
		#1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic setDivisor(input logic [15:0] div);
		apbWrite(`UART_ADDR_LCR, 8'h1 << `UART_LCR_DLAB);
		apbWrite(`UART_ADDR_RBR, div[7:0]);
		apbWrite(`UART_ADDR_DLM, div[15:8]);
		apbWrite(`UART_ADDR_LCR, 8'h00);
	endtask

	task automatic waitLsrBits(input string testName, input logic [7:0] mask,
		output logic [7:0] lsr);
		int polls;
		polls = 0;
		apbRead(`UART_ADDR_LSR, lsr);
		while ((lsr & mask) != mask && polls < maxPolls)
		begin
			apbRead(`UART_ADDR_LSR, lsr);
			polls++;
		end
		if ((lsr & mask) != mask)
		begin
			$display("%s: timed out waiting for LSR bits %h", testName, mask);
			errs++;
		end
	endtask

	// Drives one frame on SIN, starting and ending just after a rising edge
	task automatic sendFrame(input logic [7:0] data, input logic stopLvl);
		int i;
		SIN = 1'b0;
		repeat (bitClks) @(posedge CLK);
		#1;
		for (i = 0; i < 8; i++)
		begin
			SIN = data[i];
			repeat (bitClks) @(posedge CLK);
			#1;
		end
		SIN = stopLvl;
		repeat (bitClks) @(posedge CLK);
		#1;
		SIN = 1'b1;
	endtask

	// Waits for a start edge on SOUT, then samples every bit at its centre
	task automatic sampleFrame(output logic [7:0] data, output logic startLvl,
		output logic stopLvl, output bit found);
		int waited;
		int i;
		waited = 0;
		data = '0;
		startLvl = 1'b1;
		stopLvl = 1'b0;
		while (SOUT === 1'b1 && waited < maxPolls)
		begin
			@(posedge CLK);
			#1;
			waited++;
		end
		found = (SOUT === 1'b0);
		if (found)
		begin
			repeat (bitClks / 2) @(posedge CLK);
			#1;
			startLvl = SOUT;
			for (i = 0; i < 8; i++)
			begin
				repeat (bitClks) @(posedge CLK);
				#1;
				data[i] = SOUT;
			end
			repeat (bitClks) @(posedge CLK);
			#1;
			stopLvl = SOUT;
		end
	endtask

	task automatic checkResetState();
		logic [7:0] val;
		errs = 0;
		apbRead(`UART_ADDR_LSR, val);
		if (val !== lsrIdle)
			wrongValue("reset", "LSR", lsrIdle, val);
		apbWrite(`UART_ADDR_LCR, 8'h1 << `UART_LCR_DLAB);
		apbRead(`UART_ADDR_RBR, val);
		if (val !== 8'h01)
			wrongValue("reset", "DLL", 8'h01, val);
		apbWrite(`UART_ADDR_LCR, 8'h00);
		if (SOUT !== 1'b1)
			wrongValue("reset", "SOUT", 8'h01, {7'h0, SOUT});
		finishTest("reset");
	endtask

	task automatic registerAccess();
		logic [7:0] val;
		logic [7:0] scrVal;
		logic [7:0] lcrVal;
		logic [7:0] dllVal;
		logic [7:0] dlmVal;
		errs = 0;
		scrVal = 8'($urandom);
		lcrVal = 8'($urandom);
		dllVal = 8'($urandom);
		// Small DLM keeps the next baud reload short
		dlmVal = 8'($urandom_range(3, 1));
		apbWrite(`UART_ADDR_SCR, scrVal);
		apbRead(`UART_ADDR_SCR, val);
		if (val !== scrVal)
			wrongValue("registers", "SCR", scrVal, val);
		apbWrite(`UART_ADDR_LCR, lcrVal);
		apbRead(`UART_ADDR_LCR, val);
		if (val !== lcrVal)
			wrongValue("registers", "LCR", lcrVal, val);
		apbWrite(`UART_ADDR_LCR, 8'h1 << `UART_LCR_DLAB);
		apbWrite(`UART_ADDR_RBR, dllVal);
		apbWrite(`UART_ADDR_DLM, dlmVal);
		apbRead(`UART_ADDR_RBR, val);
		if (val !== dllVal)
			wrongValue("registers", "DLL", dllVal, val);
		apbRead(`UART_ADDR_DLM, val);
		if (val !== dlmVal)
			wrongValue("registers", "DLM", dlmVal, val);
		apbWrite(`UART_ADDR_LCR, 8'h00);
		apbRead(`UART_ADDR_DLM, val);
		if (val !== 8'h00)
			wrongValue("registers", "offset 1 without DLAB", 8'h00, val);
		finishTest("registers");
	endtask

	task automatic loopbackTraffic();
		logic [7:0] sent [4];
		logic [7:0] val;
		logic [7:0] lsr;
		int i;
		errs = 0;
		setDivisor(16'(divVal));
		apbWrite(`UART_ADDR_MCR, 8'h1 << `UART_MCR_LOOP);
		soutDropped = 1'b0;
		watchSout = 1'b1;
		for (i = 0; i < 4; i++)
		begin
			sent[i] = 8'($urandom);
			apbWrite(`UART_ADDR_RBR, sent[i]);
		end
		for (i = 0; i < 4; i++)
		begin
			waitLsrBits("loopback", lsrDr, lsr);
			apbRead(`UART_ADDR_RBR, val);
			if (val !== sent[i])
				wrongValue("loopback", "RBR", sent[i], val);
		end
		waitLsrBits("loopback", lsrIdle, lsr);
		if (lsr !== lsrIdle)
			wrongValue("loopback", "final LSR", lsrIdle, lsr);
		watchSout = 1'b0;
		if (soutDropped)
		begin
			$display("loopback: SOUT left the idle level while loopback was on");
			errs++;
		end
		apbWrite(`UART_ADDR_MCR, 8'h00);
		finishTest("loopback");
	endtask

	task automatic serialTransmit();
		logic [7:0] sent;
		logic [7:0] got;
		logic [7:0] lsr;
		logic       startLvl;
		logic       stopLvl;
		bit         found;
		errs = 0;
		sent = 8'($urandom);
		fork
			sampleFrame(got, startLvl, stopLvl, found);
			begin
				apbWrite(`UART_ADDR_RBR, sent);
				waitLsrBits("transmit", lsrThre, lsr);
				if ((lsr & lsrTemt) !== 8'h00)
					wrongValue("transmit", "TEMT during frame", 8'h00, lsr & lsrTemt);
			end
		join
		if (!found)
		begin
			$display("transmit: no start bit appeared on SOUT");
			errs++;
		end
		else
		begin
			if (startLvl !== 1'b0)
				wrongValue("transmit", "start bit", 8'h00, {7'h0, startLvl});
			if (got !== sent)
				wrongValue("transmit", "data bits", sent, got);
			if (stopLvl !== 1'b1)
				wrongValue("transmit", "stop bit", 8'h01, {7'h0, stopLvl});
		end
		waitLsrBits("transmit", lsrTemt, lsr);
		if (lsr !== lsrIdle)
			wrongValue("transmit", "final LSR", lsrIdle, lsr);
		finishTest("transmit");
	endtask

	task automatic receiveErrors();
		logic [7:0] sent [17];
		logic [7:0] val;
		int i;
		errs = 0;
		sent[0] = 8'($urandom);
		sendFrame(sent[0], 1'b0);
		apbRead(`UART_ADDR_LSR, val);
		if (val !== (lsrIdle | lsrDr | lsrFe))
			wrongValue("rx errors", "LSR after bad stop", lsrIdle | lsrDr | lsrFe, val);
		apbRead(`UART_ADDR_RBR, val);
		if (val !== sent[0])
			wrongValue("rx errors", "RBR after bad stop", sent[0], val);
		apbRead(`UART_ADDR_LSR, val);
		if (val !== lsrIdle)
			wrongValue("rx errors", "LSR after reading bad byte", lsrIdle, val);
		// One frame more than the RX FIFO holds
		for (i = 0; i < 17; i++)
		begin
			sent[i] = 8'($urandom);
			sendFrame(sent[i], 1'b1);
		end
		apbRead(`UART_ADDR_LSR, val);
		if (val !== (lsrIdle | lsrDr | lsrOe))
			wrongValue("rx errors", "LSR after overrun", lsrIdle | lsrDr | lsrOe, val);
		for (i = 0; i < 16; i++)
		begin
			apbRead(`UART_ADDR_RBR, val);
			if (val !== sent[i])
				wrongValue("rx errors", "RBR after overrun", sent[i], val);
		end
		apbRead(`UART_ADDR_LSR, val);
		if (val !== lsrIdle)
			wrongValue("rx errors", "second LSR read", lsrIdle, val);
		finishTest("rx errors");
	endtask

	initial
	begin
		int unsigned seedInit;
		seedInit = $urandom(32'h8155_023f);
		CLK = 1'b0;
		iRST = 1'b1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		SIN = 1'b1;
		passCount = 0;
		failCount = 0;
		errs = 0;
		watchSout = 1'b0;
		soutDropped = 1'b0;
		repeat (10) @(posedge CLK);
		#1;
		iRST = 1'b0;
		checkResetState();
		registerAccess();
		loopbackTraffic();
		serialTransmit();
		receiveErrors();
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src/apbUart.sv ====
// APB UART top, 16550-style map with fixed 8N1 framing
// FIFO mode is always on, no interrupts or modem lines
// In loopback SOUT is held high and the receiver listens to the transmitter
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module apbUart (
	input  logic        CLK,
	input  logic        iRST,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [2:0]  PADDR,
	input  logic [31:0] PWDATA,
	input  logic        SIN,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        SOUT
);
	logic [`UART_DIV_WIDTH-1:0] divisor;
	logic                       loop;
	logic                       tick16;
	logic                       txPush;
	logic                       txClear;
	logic                       txPop;
	logic                       txFull;
	logic                       txEmpty;
	logic                       txBusy;
	logic                       txSerial;
	apbUartPkg::uartByte         txPushData;
	apbUartPkg::uartByte         txHead;
	logic                       rxPush;
	logic                       rxPop;
	logic                       rxClear;
	logic                       rxFull;
	logic                       rxEmpty;
	logic                       rxValid;
	logic                       rxIn;
	apbUartPkg::rxEntry          rxData;
	apbUartPkg::rxEntry          rxHead;

	assign PREADY = 1'b1;
	assign rxIn = loop ? txSerial : SIN;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			SOUT <= 1'b1;
		else
			SOUT <= loop ? 1'b1 : txSerial;
	end

	uartRegs regs (
		.CLK, .iRST, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA,
		.divisor, .loop, .txPush, .txClear, .txPushData, .txFull, .txEmpty, .txBusy,
		.rxPop, .rxClear, .rxEmpty, .rxFull, .rxValid, .rxData, .rxHead, .rxPush
	);

	baudGen baud (.CLK, .iRST, .divisor, .tick16);

	syncFifo #(.payloadT(apbUartPkg::uartByte), .depth(`UART_FIFO_DEPTH)) txFifo (
		.CLK, .iRST, .clear(txClear), .push(txPush), .pop(txPop),
		.pushData(txPushData), .popData(txHead), .empty(txEmpty), .full(txFull)
	);

	syncFifo #(.payloadT(apbUartPkg::rxEntry), .depth(`UART_FIFO_DEPTH)) rxFifo (
		.CLK, .iRST, .clear(rxClear), .push(rxPush), .pop(rxPop),
		.pushData(rxData), .popData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	uartTx tx (
		.CLK, .iRST, .tick16, .txValid(!txEmpty), .txData(txHead),
		.txPop, .busy(txBusy), .serialOut(txSerial)
	);

	uartRx rx (.CLK, .iRST, .tick16, .serialIn(rxIn), .rxValid, .rxData);

endmodule

// ==== src/uartRegs.sv ====
// APB register block, zero wait states, only PWDATA[7:0] is used
// Writes land on the edge with PSEL and PENABLE high, PRDATA decodes PADDR alone
// THR writes to a full TX FIFO and bytes arriving at a full RX FIFO are lost
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module uartRegs (
	input  logic                       CLK,
	input  logic                       iRST,
	input  logic                       PSEL,
	input  logic                       PENABLE,
	input  logic                       PWRITE,
	input  logic [2:0]                 PADDR,
	input  logic [31:0]                PWDATA,
	output logic [31:0]                PRDATA,
	output logic [`UART_DIV_WIDTH-1:0] divisor,
	output logic                       loop,
	output logic                       txPush,
	output logic                       txClear,
	output apbUartPkg::uartByte         txPushData,
	input  logic                       txFull,
	input  logic                       txEmpty,
	input  logic                       txBusy,
	output logic                       rxPop,
	output logic                       rxClear,
	input  logic                       rxEmpty,
	input  logic                       rxFull,
	input  logic                       rxValid,
	input  apbUartPkg::rxEntry          rxData,
	input  apbUartPkg::rxEntry          rxHead,
	output logic                       rxPush
);
	logic       wrEn;
	logic       rdEn;
	logic       dlab;
	logic       rbrRead;
	logic       lsrRead;
	logic [7:0] dll;
	logic [7:0] dlm;
	logic [7:0] lcr;
	logic [7:0] mcr;
	logic [7:0] scr;
	logic [7:0] lsr;
	logic       oe;

	assign wrEn = PSEL && PENABLE && PWRITE;
	assign rdEn = PSEL && PENABLE && !PWRITE;
	assign dlab = lcr[`UART_LCR_DLAB];
	assign rbrRead = rdEn && PADDR == `UART_ADDR_RBR && !dlab;
	assign lsrRead = rdEn && PADDR == `UART_ADDR_LSR;

	assign divisor = {dlm, dll};
	assign loop = mcr[`UART_MCR_LOOP];

	assign txPush = wrEn && PADDR == `UART_ADDR_RBR && !dlab && !txFull;
	assign txPushData = PWDATA[7:0];
	assign rxPop = rbrRead && !rxEmpty;
	assign rxPush = rxValid && !rxFull;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			dll <= 8'd1;
			dlm <= '0;
			lcr <= '0;
			mcr <= '0;
			scr <= '0;
			oe <= 1'b0;
			txClear <= 1'b0;
			rxClear <= 1'b0;
		end
		else
		begin
			if (wrEn && PADDR == `UART_ADDR_RBR && dlab)
				dll <= PWDATA[7:0];
			if (wrEn && PADDR == `UART_ADDR_DLM && dlab)
				dlm <= PWDATA[7:0];
			if (wrEn && PADDR == `UART_ADDR_LCR)
				lcr <= PWDATA[7:0];
			if (wrEn && PADDR == `UART_ADDR_MCR)
				mcr <= PWDATA[7:0];
			if (wrEn && PADDR == `UART_ADDR_SCR)
				scr <= PWDATA[7:0];
			// FIFO clears pulse on the cycle after the FCR write
			txClear <= wrEn && PADDR == `UART_ADDR_FCR && PWDATA[`UART_FCR_TXCLR];
			rxClear <= wrEn && PADDR == `UART_ADDR_FCR && PWDATA[`UART_FCR_RXCLR];
			// Overrun beats the clearing read
			if (rxValid && rxFull)
				oe <= 1'b1;
			else if (lsrRead)
				oe <= 1'b0;
		end
	end

	always_comb
	begin
		lsr = '0;
		lsr[`UART_LSR_DR] = !rxEmpty;
		lsr[`UART_LSR_OE] = oe;
		lsr[`UART_LSR_FE] = !rxEmpty && rxHead.frameErr;
		lsr[`UART_LSR_THRE] = txEmpty;
		lsr[`UART_LSR_TEMT] = txEmpty && !txBusy;
	end

	always_comb
	begin
		PRDATA = '0;
		case (PADDR)
			`UART_ADDR_RBR: PRDATA[7:0] = dlab ? dll : rxHead.data;
			`UART_ADDR_DLM: PRDATA[7:0] = dlab ? dlm : 8'h00;
			`UART_ADDR_LCR: PRDATA[7:0] = lcr;
			`UART_ADDR_MCR: PRDATA[7:0] = mcr;
			`UART_ADDR_LSR: PRDATA[7:0] = lsr;
			`UART_ADDR_SCR: PRDATA[7:0] = scr;
			default: PRDATA = '0;
		endcase
	end

	// Reading RBR on an empty FIFO must leave it untouched
	assert property (@(posedge CLK) disable iff (iRST)
		(rbrRead && rxEmpty && !rxPush) |=> rxEmpty)
		else $error("uartRegs RBR read changed an empty RX FIFO");

	// A byte pushed into an empty RX FIFO is at the head on the next cycle
	assert property (@(posedge CLK) disable iff (iRST)
		(rxPush && rxEmpty && !rxClear) |=> (rxHead == $past(rxData)))
		else $error("uartRegs RX FIFO head does not match pushed byte");

endmodule

// ==== src/uartRx.sv ====
// 8N1 receiver with a two-flop input synchroniser
// Start is seen on a tick, confirmed at mid-bit, then bits are sampled 16 ticks apart
// rxValid pulses at the stop-bit sample, frameErr marks a low stop bit
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module uartRx (
	input  logic              CLK,
	input  logic              iRST,
	input  logic              tick16,
	input  logic              serialIn,
	output logic              rxValid,
	output apbUartPkg::rxEntry rxData
);
	localparam int tickW = $clog2(`UART_OVERSAMPLE);
	localparam logic [tickW-1:0] lastTick = tickW'(`UART_OVERSAMPLE - 1);
	localparam logic [tickW-1:0] midTick = tickW'(`UART_OVERSAMPLE / 2 - 1);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} rxState;

	rxState              state;
	logic                syncMeta;
	logic                rxLine;
	logic [tickW-1:0]    tickCnt;
	logic [2:0]          bitCnt;
	apbUartPkg::uartByte shiftReg;
	logic                sampleNow;

	// Line idles high
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			syncMeta <= 1'b1;
			rxLine <= 1'b1;
		end
		else
		begin
			syncMeta <= serialIn;
			rxLine <= syncMeta;
		end
	end

	assign sampleNow = tick16 && (tickCnt == lastTick);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= stIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			if (tick16)
			begin
				case (state)
					stIdle:
						if (!rxLine)
						begin
							tickCnt <= '0;
							state <= stStart;
						end
					stStart:
						if (tickCnt == midTick)
						begin
							// High at mid-bit is a glitch, not a start bit
							tickCnt <= '0;
							bitCnt <= '0;
							state <= rxLine ? stIdle : stData;
						end
						else
							tickCnt <= tickCnt + 1'b1;
					stData:
						if (tickCnt == lastTick)
						begin
							tickCnt <= '0;
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == 3'd7)
								state <= stStop;
						end
						else
							tickCnt <= tickCnt + 1'b1;
					stStop:
						if (tickCnt == lastTick)
						begin
							rxValid <= 1'b1;
							state <= stIdle;
						end
						else
							tickCnt <= tickCnt + 1'b1;
					default:
						state <= stIdle;
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (sampleNow && state == stData)
			shiftReg <= {rxLine, shiftReg[7:1]};
		if (sampleNow && state == stStop)
		begin
			rxData.data <= shiftReg;
			rxData.frameErr <= !rxLine;
		end
	end

endmodule

// ==== src/uartTx.sv ====
// 8N1 transmitter fed from the TX FIFO head
// A byte is loaded and popped while idle, the frame starts on the next tick
// busy covers the whole frame including the stop bit
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module uartTx (
	input  logic               CLK,
	input  logic               iRST,
	input  logic               tick16,
	input  logic               txValid,
	input  apbUartPkg::uartByte txData,
	output logic               txPop,
	output logic               busy,
	output logic               serialOut
);
	localparam int tickW = $clog2(`UART_OVERSAMPLE);
	localparam logic [tickW-1:0] lastTick = tickW'(`UART_OVERSAMPLE - 1);

	typedef enum logic {stIdle, stShift} txState;

	txState           state;
	logic [tickW-1:0] tickCnt;
	logic [3:0]       bitCnt;
	logic [9:0]       frame;
	logic             bitStart;

	assign busy = (state == stShift);
	// A tick coinciding with the pop is not counted
	assign bitStart = (state == stShift) && tick16 && !txPop && (tickCnt == '0);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= stIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			txPop <= 1'b0;
			serialOut <= 1'b1;
		end
		else
		begin
			txPop <= 1'b0;
			case (state)
				stIdle:
					if (txValid)
					begin
						txPop <= 1'b1;
						tickCnt <= '0;
						bitCnt <= '0;
						state <= stShift;
					end
				stShift:
					if (tick16 && !txPop)
					begin
						if (bitStart && bitCnt == 4'd10)
							state <= stIdle;
						else if (bitStart)
						begin
							serialOut <= frame[0];
							bitCnt <= bitCnt + 1'b1;
						end
						tickCnt <= (tickCnt == lastTick) ? '0 : tickCnt + 1'b1;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Frame is stop, data LSB first, start, shifted out from bit 0
	always_ff @(posedge CLK)
	begin
		if (state == stIdle && txValid)
			frame <= {1'b1, txData, 1'b0};
		else if (bitStart)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

// ==== src/baudGen.sv ====
// Baud rate generator, one tick16 pulse every divisor clocks
// A divisor of 0 behaves as 1, so tick16 is then high every cycle
// A new divisor is picked up at the next reload
`timescale 1ns/1ps
`include "apbUart_consts.svh"

module baudGen (
	input  logic                       CLK,
	input  logic                       iRST,
	input  logic [`UART_DIV_WIDTH-1:0] divisor,
	output logic                       tick16
);
	logic [`UART_DIV_WIDTH-1:0] count;
	logic [`UART_DIV_WIDTH-1:0] reload;

	// Count runs divisor-1 down to 0, so one period is divisor clocks
	assign reload = (divisor == '0) ? '0 : divisor - 1'b1;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			tick16 <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= reload;
			tick16 <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick16 <= 1'b0;
		end
	end

endmodule

// ==== src/syncFifo.sv ====
// Single-clock FIFO with first-word fall-through read
// popData shows the head entry and is only meaningful while empty is low
// clear wins over push and pop in the same cycle
`timescale 1ns/1ps

module syncFifo #(
	parameter type payloadT = logic [7:0],
	parameter int depth = 16
) (
	input  logic    CLK,
	input  logic    iRST,
	input  logic    clear,
	input  logic    push,
	input  logic    pop,
	input  payloadT pushData,
	output payloadT popData,
	output logic    empty,
	output logic    full
);
	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	payloadT         mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;

	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == cntW'(depth));
	assign popData = mem[rdPtr];

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (push && !clear)
			mem[wrPtr] <= pushData;
	end

	// The producer and consumer own the full and empty checks
	assert property (@(posedge CLK) disable iff (iRST) !(push && full))
		else $error("syncFifo push while full");
	assert property (@(posedge CLK) disable iff (iRST) !(pop && empty))
		else $error("syncFifo pop while empty");

endmodule

// ==== src/apbUartPkg.sv ====
// Shared types for the APB UART
// The line format is fixed at 8N1, so one character is always one byte
package apbUartPkg;

	// One character on the line
	typedef logic [7:0] uartByte;

	// RX FIFO entry, the error flag travels with its byte
	typedef struct packed {
		logic    frameErr;
		uartByte data;
	} rxEntry;

endpackage

// ==== src/apbUart_consts.svh ====
// Constants for the APB UART
// Register offsets follow the 16550 map, 3-bit word offsets
// The FIFO depth must be a power of two for the pointer wrap to stay cheap
`ifndef APB_UART_CONSTS_SVH
`define APB_UART_CONSTS_SVH

`define UART_FIFO_DEPTH 16
`define UART_OVERSAMPLE 16
`define UART_DIV_WIDTH 16

`define UART_ADDR_RBR 3'd0
`define UART_ADDR_DLM 3'd1
`define UART_ADDR_FCR 3'd2
`define UART_ADDR_LCR 3'd3
`define UART_ADDR_MCR 3'd4
`define UART_ADDR_LSR 3'd5
`define UART_ADDR_SCR 3'd7

`define UART_LCR_DLAB 7
`define UART_MCR_LOOP 4
`define UART_FCR_RXCLR 1
`define UART_FCR_TXCLR 2

`define UART_LSR_DR 0
`define UART_LSR_OE 1
`define UART_LSR_FE 3
`define UART_LSR_THRE 5
`define UART_LSR_TEMT 6

`endif
